// File: Makefile
TOP := tb_gfx_memory

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: all.f
src/gfx_mem_pkg.sv
src/gfx_client_pkg.sv
src/gfx_bank_ram.sv
src/gfx_bank_arbiter.sv
src/gfx_memory_arbiter.sv
src/gfx_memory_top.sv
testbench/tb_clock_gen.sv
testbench/tb_gfx_memory.sv

// File: src/gfx_bank_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_bank_arbiter import gfx_mem_pkg::*, gfx_client_pkg::*; #(
	parameter bank_sel_t BANK_ID = 2'd0
) (
	input  wire              CLK,
	input  wire              RSTb,
	input  wire client_req_t sprite_req,
	input  wire client_req_t bg0_req,
	input  wire client_req_t bg1_req,
	input  wire client_req_t ov_req,
	input  wire flash_req_t  fl_req,
	input  wire pixel_word_t dout,
	output bank_cmd_t        cmd,
	output client_rsp_t      sprite_rsp,
	output client_rsp_t      bg0_rsp,
	output client_rsp_t      bg1_rsp,
	output client_rsp_t      ov_rsp,
	output logic             fl_wready
);

	grant_state_t state;
	grant_state_t state_next;

	logic hit_sprite;
	logic hit_bg0;
	logic hit_bg1;
	logic hit_ov;
	logic hit_fl;

	function automatic bank_sel_t bank_of(input mem_addr_t a);
		return a[15:14];
	endfunction

	function automatic bank_cmd_t read_cmd(input mem_addr_t a, input logic en);
		bank_cmd_t c;
		c = '0;
		c.addr = a[13:0];
		c.req = en;
		return c;
	endfunction

	function automatic bank_cmd_t write_cmd(input flash_req_t f);
		bank_cmd_t c;
		c.addr = f.addr[13:0];
		c.din = f.data;
		c.req = f.valid;
		c.wr = f.valid;	// wr drops together with valid
		return c;
	endfunction

	function automatic client_rsp_t rsp_of(input logic v, input pixel_word_t d);
		client_rsp_t r;
		r.data = v ? d : '0;
		r.ready = v;
		return r;
	endfunction

	// valid clients that address this bank
	assign hit_sprite = sprite_req.valid && (bank_of(sprite_req.addr) == BANK_ID);
	assign hit_bg0    = bg0_req.valid && (bank_of(bg0_req.addr) == BANK_ID);
	assign hit_bg1    = bg1_req.valid && (bank_of(bg1_req.addr) == BANK_ID);
	assign hit_ov     = ov_req.valid && (bank_of(ov_req.addr) == BANK_ID);
	assign hit_fl     = fl_req.valid && (bank_of(fl_req.addr) == BANK_ID);

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state <= s_idle;
		else
			state <= state_next;
	end

	always_comb begin
		cmd = '0;
		sprite_rsp = '0;
		bg0_rsp = '0;
		bg1_rsp = '0;
		ov_rsp = '0;
		fl_wready = 1'b0;
		state_next = state;

		case (state)
			s_idle: begin
				// request goes out now, ready follows next cycle
				if (hit_sprite) begin
					cmd = read_cmd(sprite_req.addr, 1'b1);
					state_next = s_grant_sprite;
				end else if (hit_bg0) begin
					cmd = read_cmd(bg0_req.addr, 1'b1);
					state_next = s_grant_bg0;
				end else if (hit_bg1) begin
					cmd = read_cmd(bg1_req.addr, 1'b1);
					state_next = s_grant_bg1;
				end else if (hit_ov) begin
					cmd = read_cmd(ov_req.addr, 1'b1);
					state_next = s_grant_ov;
				end else if (hit_fl) begin
					cmd = write_cmd(fl_req);	// first write at this edge
					state_next = s_grant_fl;
				end
			end
			s_grant_sprite: begin
				cmd = read_cmd(sprite_req.addr, sprite_req.valid);
				sprite_rsp = rsp_of(sprite_req.valid, dout);
				if (!sprite_req.valid)
					state_next = s_idle;
			end
			s_grant_bg0: begin
				cmd = read_cmd(bg0_req.addr, bg0_req.valid);
				bg0_rsp = rsp_of(bg0_req.valid, dout);
				if (!bg0_req.valid)
					state_next = s_idle;
			end
			s_grant_bg1: begin
				cmd = read_cmd(bg1_req.addr, bg1_req.valid);
				bg1_rsp = rsp_of(bg1_req.valid, dout);
				if (!bg1_req.valid)
					state_next = s_idle;
			end
			s_grant_ov: begin
				cmd = read_cmd(ov_req.addr, ov_req.valid);
				ov_rsp = rsp_of(ov_req.valid, dout);
				if (!ov_req.valid)
					state_next = s_idle;
			end
			s_grant_fl: begin
				cmd = write_cmd(fl_req);	// rewrites each cycle of the grant
				fl_wready = fl_req.valid;
				if (!fl_req.valid)
					state_next = s_idle;
			end
			default: state_next = s_idle;
		endcase
	end

endmodule

`default_nettype wire

// File: src/gfx_bank_ram.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_bank_ram import gfx_mem_pkg::*; #(
	parameter int ADDR_W = 14
) (
	input  wire            CLK,
	input  wire bank_cmd_t cmd,
	output pixel_word_t    dout
);

	pixel_word_t mem [0:(1 << ADDR_W) - 1];

	logic [ADDR_W-1:0] word_addr;

	assign word_addr = cmd.addr[ADDR_W-1:0];	// low bits only at smaller depths

	always_ff @(posedge CLK) begin
		if (cmd.req) begin
			if (cmd.wr)
				mem[word_addr] <= cmd.din;
			else
				dout <= mem[word_addr];	// held while idle
		end
	end

endmodule

`default_nettype wire

// File: src/gfx_client_pkg.sv
`default_nettype none

package gfx_client_pkg;

	import gfx_mem_pkg::*;

	typedef struct packed {
		mem_addr_t addr;	// held steady while valid
		logic      valid;
	} client_req_t;

	typedef struct packed {
		mem_addr_t   addr;
		pixel_word_t data;
		logic        valid;
	} flash_req_t;

	typedef struct packed {
		pixel_word_t data;	// zero unless ready
		logic        ready;
	} client_rsp_t;

	// priority order, sprite highest
	typedef enum logic [2:0] {
		s_idle,
		s_grant_sprite,
		s_grant_bg0,
		s_grant_bg1,
		s_grant_ov,
		s_grant_fl
	} grant_state_t;

endpackage

`default_nettype wire

// File: src/gfx_mem_pkg.sv
`default_nettype none

package gfx_mem_pkg;

	localparam int NUM_BANKS = 4;

	typedef logic [15:0] mem_addr_t;	// client word address
	typedef logic [1:0]  bank_sel_t;	// top address bits
	typedef logic [13:0] bank_addr_t;	// word address inside a bank
	typedef logic [15:0] pixel_word_t;

	// one bank's command, driven combinationally by its arbiter
	typedef struct packed {
		bank_addr_t  addr;
		pixel_word_t din;	// flash write data
		logic        req;
		logic        wr;	// only set for the flash client
	} bank_cmd_t;

endpackage

`default_nettype wire

// File: src/gfx_memory_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_memory_arbiter import gfx_mem_pkg::*, gfx_client_pkg::*; (
	input  wire              CLK,
	input  wire              RSTb,
	input  wire client_req_t sprite_req,
	input  wire client_req_t bg0_req,
	input  wire client_req_t bg1_req,
	input  wire client_req_t ov_req,
	input  wire flash_req_t  fl_req,
	input  wire pixel_word_t dout0,
	input  wire pixel_word_t dout1,
	input  wire pixel_word_t dout2,
	input  wire pixel_word_t dout3,
	output bank_cmd_t        cmd0,
	output bank_cmd_t        cmd1,
	output bank_cmd_t        cmd2,
	output bank_cmd_t        cmd3,
	output client_rsp_t      sprite_rsp,
	output client_rsp_t      bg0_rsp,
	output client_rsp_t      bg1_rsp,
	output client_rsp_t      ov_rsp,
	output logic             fl_wready
);

	pixel_word_t dout_b [NUM_BANKS];
	bank_cmd_t   cmd_b [NUM_BANKS];
	client_rsp_t sprite_rsp_b [NUM_BANKS];
	client_rsp_t bg0_rsp_b [NUM_BANKS];
	client_rsp_t bg1_rsp_b [NUM_BANKS];
	client_rsp_t ov_rsp_b [NUM_BANKS];
	logic [NUM_BANKS-1:0] fl_wready_b;

	assign dout_b[0] = dout0;
	assign dout_b[1] = dout1;
	assign dout_b[2] = dout2;
	assign dout_b[3] = dout3;

	assign cmd0 = cmd_b[0];
	assign cmd1 = cmd_b[1];
	assign cmd2 = cmd_b[2];
	assign cmd3 = cmd_b[3];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		gfx_bank_arbiter #(
			.BANK_ID(bank_sel_t'(b))
		) u_arb (
			.CLK       (CLK),
			.RSTb      (RSTb),
			.sprite_req(sprite_req),
			.bg0_req   (bg0_req),
			.bg1_req   (bg1_req),
			.ov_req    (ov_req),
			.fl_req    (fl_req),
			.dout      (dout_b[b]),
			.cmd       (cmd_b[b]),
			.sprite_rsp(sprite_rsp_b[b]),
			.bg0_rsp   (bg0_rsp_b[b]),
			.bg1_rsp   (bg1_rsp_b[b]),
			.ov_rsp    (ov_rsp_b[b]),
			.fl_wready (fl_wready_b[b])
		);
	end

	// a held address is granted in one bank at most, others give zero
	always_comb begin
		sprite_rsp = '0;
		bg0_rsp = '0;
		bg1_rsp = '0;
		ov_rsp = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			sprite_rsp = sprite_rsp | sprite_rsp_b[i];
			bg0_rsp = bg0_rsp | bg0_rsp_b[i];
			bg1_rsp = bg1_rsp | bg1_rsp_b[i];
			ov_rsp = ov_rsp | ov_rsp_b[i];
		end
	end

	assign fl_wready = |fl_wready_b;

endmodule

`default_nettype wire

// File: src/gfx_memory_top.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_memory_top import gfx_mem_pkg::*, gfx_client_pkg::*; #(
	parameter int BANK_ADDR_W = 14
) (
	input  wire              CLK,
	input  wire              RSTb,
	input  wire client_req_t sprite_req,
	input  wire client_req_t bg0_req,
	input  wire client_req_t bg1_req,
	input  wire client_req_t ov_req,
	input  wire flash_req_t  fl_req,
	output client_rsp_t      sprite_rsp,
	output client_rsp_t      bg0_rsp,
	output client_rsp_t      bg1_rsp,
	output client_rsp_t      ov_rsp,
	output logic             fl_wready
);

	bank_cmd_t   bank_cmd [NUM_BANKS];
	pixel_word_t bank_dout [NUM_BANKS];

	gfx_memory_arbiter u_arbiter (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sprite_req(sprite_req),
		.bg0_req   (bg0_req),
		.bg1_req   (bg1_req),
		.ov_req    (ov_req),
		.fl_req    (fl_req),
		.dout0     (bank_dout[0]),
		.dout1     (bank_dout[1]),
		.dout2     (bank_dout[2]),
		.dout3     (bank_dout[3]),
		.cmd0      (bank_cmd[0]),
		.cmd1      (bank_cmd[1]),
		.cmd2      (bank_cmd[2]),
		.cmd3      (bank_cmd[3]),
		.sprite_rsp(sprite_rsp),
		.bg0_rsp   (bg0_rsp),
		.bg1_rsp   (bg1_rsp),
		.ov_rsp    (ov_rsp),
		.fl_wready (fl_wready)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_ram
		gfx_bank_ram #(
			.ADDR_W(BANK_ADDR_W)
		) u_ram (
			.CLK (CLK),
			.cmd (bank_cmd[b]),
			.dout(bank_dout[b])
		);
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 10;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTb <= 1'b1;	// released on a rising edge
	end

endmodule

`default_nettype wire

// File: testbench/tb_gfx_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gfx_memory import gfx_mem_pkg::*, gfx_client_pkg::*; ();

	localparam int WAIT_LIMIT = 20;
	localparam int RESET_LIMIT = 50;

	wire CLK;
	wire RSTb;

	client_req_t sprite_req;
	client_req_t bg0_req;
	client_req_t bg1_req;
	client_req_t ov_req;
	flash_req_t  fl_req;
	client_rsp_t sprite_rsp;
	client_rsp_t bg0_rsp;
	client_rsp_t bg1_rsp;
	client_rsp_t ov_rsp;
	logic        fl_wready;

	pixel_word_t shadow [mem_addr_t];	// last word written per address
	mem_addr_t   bank_addr [NUM_BANKS];	// one written address per bank
	mem_addr_t   written [$];
	logic [31:0] lcg_state;
	int          err_count;
	int          timeout_count;

	tb_clock_gen u_clk (
		.CLK (CLK),
		.RSTb(RSTb)
	);

	gfx_memory_top #(
		.BANK_ADDR_W(14)
	) uut (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sprite_req(sprite_req),
		.bg0_req   (bg0_req),
		.bg1_req   (bg1_req),
		.ov_req    (ov_req),
		.fl_req    (fl_req),
		.sprite_rsp(sprite_rsp),
		.bg0_rsp   (bg0_rsp),
		.bg1_rsp   (bg1_rsp),
		.ov_rsp    (ov_rsp),
		.fl_wready (fl_wready)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [15:0] v);
		lcg_state = lcg_step(lcg_state);
		v = lcg_state[31:16];	// upper half has the longer period
	endtask

	function automatic string client_name(input int c);
		case (c)
			0: return "sprite";
			1: return "bg0";
			2: return "bg1";
			default: return "overlay";
		endcase
	endfunction

	function automatic client_rsp_t rsp_of_client(input int c);
		case (c)
			0: return sprite_rsp;
			1: return bg0_rsp;
			2: return bg1_rsp;
			default: return ov_rsp;
		endcase
	endfunction

	function automatic bit all_clients_ready();
		return sprite_rsp.ready === 1'b1 && bg0_rsp.ready === 1'b1 &&
			bg1_rsp.ready === 1'b1 && ov_rsp.ready === 1'b1;
	endfunction

	// called right after a rising edge
	task automatic drive_client(input int c, input mem_addr_t a, input logic v);
		client_req_t r;
		r.addr = a;
		r.valid = v;
		case (c)
			0: sprite_req <= r;
			1: bg0_req <= r;
			2: bg1_req <= r;
			default: ov_req <= r;
		endcase
	endtask

	task automatic check_word(input string who, input mem_addr_t a, input pixel_word_t got);
		if (!shadow.exists(a)) begin
			$display("ERROR %0t: %s read of %h has no written word to compare", $time, who, a);
			err_count++;
		end else if (got !== shadow[a]) begin
			$display("ERROR %0t: %s read of %h returned %h, expected %h",
				$time, who, a, got, shadow[a]);
			err_count++;
		end
	endtask

	task automatic idle_outputs_check(input string phase);
		if (sprite_rsp !== '0 || bg0_rsp !== '0 || bg1_rsp !== '0 || ov_rsp !== '0 ||
			fl_wready !== 1'b0) begin
			$display("ERROR %0t: responses not all zero %s", $time, phase);
			err_count++;
		end
	endtask

	// cycle 0 is the falling edge of the cycle that raised valid
	task automatic wait_client_ready(input int c, output int cycles, output bit ok);
		client_rsp_t r;
		cycles = 0;
		@(negedge CLK);
		r = rsp_of_client(c);
		while (r.ready !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
			r = rsp_of_client(c);
		end
		ok = (r.ready === 1'b1);
		if (!ok) begin
			$display("%s client got no ready within %0d cycles at %0t",
				client_name(c), WAIT_LIMIT, $time);
			timeout_count++;
		end
	endtask

	task automatic flash_write(input mem_addr_t a, input pixel_word_t d, input bit exact);
		flash_req_t f;
		int cycles;
		f.addr = a;
		f.data = d;
		f.valid = 1'b1;
		@(posedge CLK);
		fl_req <= f;
		cycles = 0;
		@(negedge CLK);
		while (fl_wready !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		if (fl_wready !== 1'b1) begin
			$display("flash write to %h got no ready within %0d cycles", a, WAIT_LIMIT);
			timeout_count++;
		end else begin
			shadow[a] = d;
			if (exact && cycles != 1) begin
				$display("ERROR %0t: fl_wready after %0d cycles, expected 1", $time, cycles);
				err_count++;
			end
		end
		@(posedge CLK);
		fl_req.valid <= 1'b0;
		@(negedge CLK);
		if (fl_wready !== 1'b0) begin
			$display("ERROR %0t: fl_wready still high after valid dropped", $time);
			err_count++;
		end
	endtask

	task automatic client_read(input int c, input mem_addr_t a, input bit exact);
		int cycles;
		bit ok;
		client_rsp_t r;
		@(posedge CLK);
		drive_client(c, a, 1'b1);
		wait_client_ready(c, cycles, ok);
		if (ok) begin
			r = rsp_of_client(c);
			check_word(client_name(c), a, r.data);
			if (exact && cycles != 1) begin
				$display("ERROR %0t: %s ready after %0d cycles, expected 1",
					$time, client_name(c), cycles);
				err_count++;
			end
		end
		@(posedge CLK);
		drive_client(c, a, 1'b0);
		@(negedge CLK);
		r = rsp_of_client(c);
		if (r !== '0) begin
			$display("ERROR %0t: %s response not zero after valid dropped", $time, client_name(c));
			err_count++;
		end
	endtask

	task automatic reset_state_check();
		int cycles;
		cycles = 0;
		@(posedge CLK);
		@(negedge CLK);
		while (RSTb !== 1'b1 && cycles < RESET_LIMIT) begin
			idle_outputs_check("during reset");
			@(negedge CLK);
			cycles++;
		end
		if (RSTb !== 1'b1) begin
			$display("reset was not released within %0d cycles", RESET_LIMIT);
			timeout_count++;
		end
		repeat (3) begin
			@(negedge CLK);
			idle_outputs_check("after reset");
		end
	endtask

	task automatic flash_bank_roundtrip();
		logic [15:0] r;
		logic [15:0] d;
		for (int b = 0; b < NUM_BANKS; b++) begin
			next_random(r);
			next_random(d);
			bank_addr[b] = (r & 16'h3fff) | (mem_addr_t'(b) << 14);
			flash_write(bank_addr[b], d, 1'b1);
		end
		for (int b = 0; b < NUM_BANKS; b++)
			client_read(0, bank_addr[b], 1'b1);
	endtask

	task automatic same_bank_priority();
		mem_addr_t   a_sp;
		mem_addr_t   a_bg;
		logic [15:0] d;
		int          cycles;
		bit          ok;
		a_sp = bank_addr[2];
		a_bg = bank_addr[2] ^ 16'h0001;	// neighbour word, same bank
		next_random(d);
		flash_write(a_bg, d, 1'b0);
		@(posedge CLK);
		drive_client(0, a_sp, 1'b1);
		drive_client(1, a_bg, 1'b1);
		wait_client_ready(0, cycles, ok);
		if (ok) begin
			check_word("sprite", a_sp, sprite_rsp.data);
			if (cycles != 1) begin
				$display("ERROR %0t: sprite ready after %0d cycles, expected 1", $time, cycles);
				err_count++;
			end
		end
		repeat (2) begin
			if (bg0_rsp.ready !== 1'b0) begin
				$display("ERROR %0t: bg0 ready while sprite holds the bank", $time);
				err_count++;
			end
			@(negedge CLK);
		end
		@(posedge CLK);
		drive_client(0, a_sp, 1'b0);
		wait_client_ready(1, cycles, ok);
		if (ok)
			check_word("bg0", a_bg, bg0_rsp.data);
		@(posedge CLK);
		drive_client(1, a_bg, 1'b0);
		@(negedge CLK);
		idle_outputs_check("after priority reads");
	endtask

	task automatic parallel_bank_reads();
		mem_addr_t   a [4];
		client_rsp_t r;
		int          cycles;
		bit          ready;
		@(posedge CLK);
		for (int c = 0; c < 4; c++) begin
			a[c] = bank_addr[(c + 1) % NUM_BANKS];	// each client in another bank
			drive_client(c, a[c], 1'b1);
		end
		cycles = 0;
		@(negedge CLK);
		ready = all_clients_ready();
		while (!ready && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
			ready = all_clients_ready();
		end
		if (!ready) begin
			$display("parallel reads did not all get ready within %0d cycles", WAIT_LIMIT);
			timeout_count++;
		end else begin
			if (cycles != 1) begin
				$display("ERROR %0t: parallel ready after %0d cycles, expected 1", $time, cycles);
				err_count++;
			end
			for (int c = 0; c < 4; c++) begin
				r = rsp_of_client(c);
				check_word(client_name(c), a[c], r.data);
			end
		end
		@(posedge CLK);
		for (int c = 0; c < 4; c++)
			drive_client(c, a[c], 1'b0);
		@(negedge CLK);
		idle_outputs_check("after parallel reads");
	endtask

	task automatic random_traffic();
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] pick;
		written.delete();
		for (int i = 0; i < 40; i++) begin
			next_random(a);
			next_random(d);
			flash_write(a, d, 1'b0);
			written.push_back(a);
		end
		foreach (written[i]) begin
			next_random(pick);
			client_read(int'(pick % 16'd4), written[i], 1'b0);
		end
	endtask

	initial begin
		sprite_req = '0;
		bg0_req = '0;
		bg1_req = '0;
		ov_req = '0;
		fl_req = '0;
		lcg_state = 32'h1752;
		err_count = 0;
		timeout_count = 0;

		reset_state_check();
		flash_bank_roundtrip();
		same_bank_priority();
		parallel_bank_reads();
		random_traffic();

		repeat (2) @(posedge CLK);
		$display("errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
